//--- hdl/a2r_bus_pkg.sv
// a2r register bus types
// bus widths, vector types and the request and response records
`default_nettype none

package a2r_bus_pkg;

   localparam int a2r_data_width  = 32;                 // one bus word
   localparam int a2r_addr_width  = 5;                  // slave select plus local index
   localparam int a2r_local_width = 3;                  // up to 8 registers per slave

   typedef logic [a2r_data_width-1:0]  a2r_data_t;      // register contents
   typedef logic [a2r_addr_width-1:0]  a2r_addr_t;      // host address
   typedef logic [a2r_local_width-1:0] a2r_local_t;     // index within one slave

   // registered host command
   typedef struct packed {
      logic       read;                                 // one cycle read strobe
      logic       write;                                // one cycle write strobe
      a2r_addr_t  address;
      a2r_data_t  write_data;
   } a2r_request_t;

   typedef struct packed {
      a2r_data_t  read_data;                            // combinational read mux
      logic       ready;                                // high while strobed
      logic       error;                                // bad local index
   } a2r_slave_resp_t;

   typedef struct packed {
      a2r_data_t  read_data;
      logic       ready;                                // one pulse per command
      logic       error;                                // unmapped or unused register
   } a2r_response_t;

endpackage

`default_nettype wire

//--- hdl/a2r_map_pkg.sv
// a2r address map
// slave select field and timer register layout
`default_nettype none

package a2r_map_pkg;

   localparam int a2r_sel_width = 2;                    // upper address bits

   // slave select, taken straight from the address
   typedef enum logic [a2r_sel_width-1:0] {
      slave_registers = 2'd0,                           // general register bank
      slave_timer     = 2'd1,                           // counter / compare block
      slave_none_2    = 2'd2,                           // nothing mapped here
      slave_none_3    = 2'd3
   } a2r_slave_sel_e;

   ////////////////////////////////
   // timer local indices
   ////////////////////////////////
   localparam a2r_bus_pkg::a2r_local_t timer_reg_count   = 3'd0;  // loadable counter
   localparam a2r_bus_pkg::a2r_local_t timer_reg_control = 3'd1;  // bit 0 enables counting
   localparam a2r_bus_pkg::a2r_local_t timer_reg_compare = 3'd2;  // match value
   localparam a2r_bus_pkg::a2r_local_t timer_reg_status  = 3'd3;  // bit 0 sticky match, w1c

endpackage

`default_nettype wire

//--- hdl/a2r_request_stage.sv
// a2r request stage
// registers the host strobes, address and data into one request
`timescale 1ns/1ns
`default_nettype none

module a2r_request_stage (
   input  logic                      clock,
   input  logic                      reset,
   input  logic                      read,
   input  logic                      write,
   input  a2r_bus_pkg::a2r_addr_t    address,
   input  a2r_bus_pkg::a2r_data_t    write_data,
   output a2r_bus_pkg::a2r_request_t request
);

   logic strobe;                                        // any access this cycle

   assign strobe = read | write;

   always_ff @(posedge clock) begin
      if (reset) begin
         request.read  <= 1'b0;                         // no command in flight
         request.write <= 1'b0;
      end else begin
         request.read  <= read;
         request.write <= write;
      end
      // bus keeps its last value between accesses
      if (strobe) begin
         request.address    <= address;
         request.write_data <= write_data;
      end
   end

endmodule

`default_nettype wire

//--- hdl/a2r_address_decode.sv
// a2r address decode
// splits the request address into slave select and local index
// and steers the strobes to the selected slave only
`timescale 1ns/1ns
`default_nettype none

module a2r_address_decode (
   input  a2r_bus_pkg::a2r_request_t   request,
   output a2r_map_pkg::a2r_slave_sel_e sel,
   output a2r_bus_pkg::a2r_local_t     local_index,
   output logic                        reg_read,
   output logic                        reg_write,
   output logic                        timer_read,
   output logic                        timer_write,
   output a2r_bus_pkg::a2r_data_t      write_data
);

   import a2r_bus_pkg::*;
   import a2r_map_pkg::*;

   logic reg_hit;                                       // register bank selected
   logic timer_hit;                                     // timer selected

   ////////////////////////////////
   // address split
   ////////////////////////////////
   assign sel         = a2r_slave_sel_e'(request.address[a2r_addr_width-1 -: a2r_sel_width]);
   assign local_index = request.address[a2r_local_width-1:0];

   assign reg_hit   = (sel == slave_registers);
   assign timer_hit = (sel == slave_timer);

   // unmapped selects reach no slave
   assign reg_read    = request.read  & reg_hit;
   assign reg_write   = request.write & reg_hit;
   assign timer_read  = request.read  & timer_hit;
   assign timer_write = request.write & timer_hit;

   assign write_data = request.write_data;              // shared by both slaves

endmodule

`default_nettype wire

//--- hdl/a2r_register_slave.sv
// a2r register slave
// general purpose register bank with a combinational read mux
`timescale 1ns/1ns
`default_nettype none

module a2r_register_slave #(
   parameter int register_count = 7                     // implemented registers, 1 to 8
) (
   input  logic                         clock,
   input  logic                         reset,
   input  logic                         read,
   input  logic                         write,
   input  a2r_bus_pkg::a2r_local_t      local_index,
   input  a2r_bus_pkg::a2r_data_t       write_data,
   output a2r_bus_pkg::a2r_slave_resp_t resp
);

   import a2r_bus_pkg::*;

   a2r_data_t registers [register_count];               // the bank itself
   logic      index_valid;                              // index maps to a register
   logic      strobe;

   assign index_valid = (int'(local_index) < register_count);
   assign strobe      = read | write;

   ////////////////////////////////
   // register bank
   ////////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < register_count; i++) begin
            registers[i] <= '0;
         end
      end else if (write && index_valid) begin      // writes above the bank are dropped
         registers[local_index] <= write_data;
      end
   end

   // read mux, unused indices give zero
   assign resp.read_data = index_valid ? registers[local_index] : '0;
   assign resp.ready     = strobe;                      // single cycle slave
   assign resp.error     = strobe & ~index_valid;

endmodule

`default_nettype wire

//--- hdl/a2r_timer_slave.sv
// a2r timer slave
// loadable counter with enable, compare value and sticky match flag
`timescale 1ns/1ns
`default_nettype none

module a2r_timer_slave (
   input  logic                         clock,
   input  logic                         reset,
   input  logic                         read,
   input  logic                         write,
   input  a2r_bus_pkg::a2r_local_t      local_index,
   input  a2r_bus_pkg::a2r_data_t       write_data,
   output a2r_bus_pkg::a2r_slave_resp_t resp
);

   import a2r_bus_pkg::*;
   import a2r_map_pkg::*;

   a2r_data_t count;                                    // running counter
   a2r_data_t control;                                  // bit 0 = enable
   a2r_data_t compare;
   logic      match;                                    // status bit 0
   logic      enable;

   assign enable = control[0];

   ////////////////////////////////
   // counter and registers
   ////////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         count   <= '0;
         control <= '0;
         compare <= '0;
         match   <= 1'b0;
      end else begin
         if (write && local_index == timer_reg_count)
            count <= write_data;                        // load beats increment
         else if (enable)
            count <= count + 1'b1;
         if (write && local_index == timer_reg_control)
            control <= write_data;
         if (write && local_index == timer_reg_compare)
            compare <= write_data;
         if (enable && count == compare)
            match <= 1'b1;                              // set wins over clear
         else if (write && local_index == timer_reg_status && write_data[0])
            match <= 1'b0;                              // write 1 to clear
      end
   end

   // read mux
   always_comb begin
      resp.ready = read | write;
      resp.error = 1'b0;
      case (local_index)
         timer_reg_count:   resp.read_data = count;
         timer_reg_control: resp.read_data = control;
         timer_reg_compare: resp.read_data = compare;
         timer_reg_status:  resp.read_data = a2r_data_t'(match);
         default: begin                                 // indices 4 to 7 unused
            resp.read_data = '0;
            resp.error     = read | write;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/a2r_response_stage.sv
// a2r response stage
// picks the selected slave response and registers it for the host
`timescale 1ns/1ns
`default_nettype none

module a2r_response_stage (
   input  logic                         clock,
   input  logic                         reset,
   input  a2r_map_pkg::a2r_slave_sel_e  sel,
   input  a2r_bus_pkg::a2r_request_t    request,
   input  a2r_bus_pkg::a2r_slave_resp_t reg_resp,
   input  a2r_bus_pkg::a2r_slave_resp_t timer_resp,
   output a2r_bus_pkg::a2r_response_t   response
);

   import a2r_bus_pkg::*;
   import a2r_map_pkg::*;

   a2r_response_t selected;                             // response before the register
   logic          strobe;

   assign strobe = request.read | request.write;

   ////////////////////////////////
   // slave mux
   ////////////////////////////////
   always_comb begin
      case (sel)
         slave_registers: begin
            selected.read_data = reg_resp.read_data;
            selected.ready     = reg_resp.ready;
            selected.error     = reg_resp.error;
         end
         slave_timer: begin
            selected.read_data = timer_resp.read_data;
            selected.ready     = timer_resp.ready;
            selected.error     = timer_resp.error;
         end
         default: begin                                 // nothing mapped, answer here
            selected.read_data = '0;
            selected.ready     = strobe;
            selected.error     = strobe;
         end
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset)
         response.ready <= 1'b0;
      else
         response.ready <= selected.ready;              // one pulse per command
      response.read_data <= selected.read_data;         // pre-write register contents
      response.error     <= selected.error;
   end

endmodule

`default_nettype wire

//--- hdl/a2r_register_bus.sv
// a2r register bus
// request, decode, two slaves and response in a two cycle pipeline
`timescale 1ns/1ns
`default_nettype none

module a2r_register_bus #(
   parameter int register_count = 7                     // size of the register bank
) (
   input  logic                       clock,
   input  logic                       reset,
   input  logic                       read,
   input  logic                       write,
   input  a2r_bus_pkg::a2r_addr_t     address,
   input  a2r_bus_pkg::a2r_data_t     write_data,
   output a2r_bus_pkg::a2r_response_t response
);

   import a2r_bus_pkg::*;
   import a2r_map_pkg::*;

   a2r_request_t    request;                            // registered command
   a2r_slave_sel_e  sel;
   a2r_local_t      local_index;
   logic            reg_read;
   logic            reg_write;
   logic            timer_read;
   logic            timer_write;
   a2r_data_t       slave_write_data;
   a2r_slave_resp_t reg_resp;
   a2r_slave_resp_t timer_resp;

   a2r_request_stage i_request_stage (
      .clock      (clock),
      .reset      (reset),
      .read       (read),
      .write      (write),
      .address    (address),
      .write_data (write_data),
      .request    (request)
   );

   a2r_address_decode i_address_decode (
      .request     (request),
      .sel         (sel),
      .local_index (local_index),
      .reg_read    (reg_read),
      .reg_write   (reg_write),
      .timer_read  (timer_read),
      .timer_write (timer_write),
      .write_data  (slave_write_data)
   );

   ////////////////////////////////
   // slaves
   ////////////////////////////////
   a2r_register_slave #(
      .register_count (register_count)
   ) i_register_slave (
      .clock       (clock),
      .reset       (reset),
      .read        (reg_read),
      .write       (reg_write),
      .local_index (local_index),
      .write_data  (slave_write_data),
      .resp        (reg_resp)
   );

   a2r_timer_slave i_timer_slave (
      .clock       (clock),
      .reset       (reset),
      .read        (timer_read),
      .write       (timer_write),
      .local_index (local_index),
      .write_data  (slave_write_data),
      .resp        (timer_resp)
   );

   a2r_response_stage i_response_stage (
      .clock      (clock),
      .reset      (reset),
      .sel        (sel),
      .request    (request),
      .reg_resp   (reg_resp),
      .timer_resp (timer_resp),
      .response   (response)
   );

endmodule

`default_nettype wire

//--- test/a2r_register_bus_asserts.sv
// a2r register bus protocol checks
// bound to the top level, watches strobes, request and ready
`timescale 1ns/1ns
`default_nettype none

module a2r_register_bus_asserts (
   input logic                       clock,
   input logic                       reset,
   input logic                       read,
   input logic                       write,
   input a2r_bus_pkg::a2r_request_t  request,
   input a2r_bus_pkg::a2r_response_t response
);

   int failures = 0;                                    // failed checks so far

   ////////////////////////////////
   // response pulse
   ////////////////////////////////
   // two ready cycles in a row need two strobes behind them
   ready_has_strobe: assert property (@(posedge clock) disable iff (reset)
      (response.ready && $past(response.ready)) |->
         ($past(read || write, 2) && $past(read || write, 3)))
      else begin
         failures++;
         $error("ready held for two cycles without two strobes behind it");
      end

   ////////////////////////////////
   // request and reset
   ////////////////////////////////
   single_strobe: assert property (@(posedge clock) disable iff (reset)
      !(request.read && request.write))                 // host must not overlap
      else begin
         failures++;
         $error("request carries read and write at the same time");
      end

   quiet_in_reset: assert property (@(posedge clock)
      (reset ##1 reset) |-> !response.ready)            // first edge clears it
      else begin
         failures++;
         $error("ready is high while reset is held");
      end

endmodule

bind a2r_register_bus a2r_register_bus_asserts i_asserts (
   .clock    (clock),
   .reset    (reset),
   .read     (read),
   .write    (write),
   .request  (request),
   .response (response)
);

`default_nettype wire

//--- test/a2r_register_bus_tb.sv
// a2r register bus testbench
// random and directed commands against a shadow model, checked by assertions
`timescale 1ns/1ns
`default_nettype none

module a2r_register_bus_tb;

   import a2r_bus_pkg::*;
   import a2r_map_pkg::*;

   localparam int register_count = 7;
   localparam int random_writes  = 32;
   localparam int mixed_commands = 48;
   // reset reads 12, pairs 16, readback 7, unused 21, unmapped 8, timer 9
   localparam int command_count  = 73 + random_writes + mixed_commands;
   localparam int cycle_limit    = 2 * command_count + 100;

   logic          clock = 1'b0;
   logic          reset;
   logic          read;
   logic          write;
   a2r_addr_t     address;
   a2r_data_t     write_data;
   a2r_response_t response;
   a2r_response_t expected;                             // model answer for the strobe
   a2r_response_t expected_d1;
   a2r_response_t expected_d2;                          // lines up with ready
   a2r_response_t pending [$];                          // commands still in flight
   a2r_data_t     bank_model [8];                       // index 7 stays zero
   a2r_data_t     count_model;
   a2r_data_t     control_model;
   a2r_data_t     compare_model;
   logic          status_model;
   int            cycle_count = 0;

   a2r_register_bus #(.register_count(register_count)) i_dut (
      .clock      (clock),
      .reset      (reset),
      .read       (read),
      .write      (write),
      .address    (address),
      .write_data (write_data),
      .response   (response)
   );

   always #10 clock = ~clock;                           // 20 ns period

   always @(posedge clock) begin
      expected_d1 <= expected;
      expected_d2 <= expected_d1;
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("Timeout: commands did not finish within %0d cycles", cycle_limit);
         $display("Done: errors found");
         $fatal(1, "timeout");
      end
   end

   always @(negedge clock) begin
      if (response.ready) begin
         if (pending.size() == 0) begin
            $display("Ready pulse at %0t with no command pending", $time);
            $display("Done: errors found");
            $fatal(1, "unexpected ready");
         end else begin
            void'(pending.pop_front());                 // retire oldest command
         end
      end
   end

   task automatic report_mismatch(input string name, input a2r_data_t want, input a2r_data_t got);
      $display("Error at %0t: %s expected %h got %h", $time, name, want, got);
      $display("Done: errors found");
      $fatal(1, "response mismatch");
   endtask

   ////////////////////////////////
   // response checks
   ////////////////////////////////
   ready_after_strobe: assert property (@(posedge clock) disable iff (reset)
      (read || write) |-> ##2 response.ready)
      else report_mismatch("response.ready", 32'd1, a2r_data_t'($sampled(response.ready)));

   data_after_strobe: assert property (@(posedge clock) disable iff (reset)
      (read || write) |-> ##2 (response.read_data == expected_d2.read_data))
      else report_mismatch("response.read_data", $sampled(expected_d2.read_data),
                           $sampled(response.read_data));

   error_after_strobe: assert property (@(posedge clock) disable iff (reset)
      (read || write) |-> ##2 (response.error == expected_d2.error))
      else report_mismatch("response.error", a2r_data_t'($sampled(expected_d2.error)),
                           a2r_data_t'($sampled(response.error)));

   function automatic a2r_addr_t bank_address(input a2r_local_t idx);
      return {slave_registers, idx};
   endfunction

   function automatic a2r_addr_t timer_address(input a2r_local_t idx);
      return {slave_timer, idx};
   endfunction

   // what the host should see, taken before any write of the same command
   function automatic a2r_response_t expected_response(input a2r_addr_t addr);
      a2r_response_t resp;
      a2r_local_t    idx;
      idx  = addr[a2r_local_width-1:0];
      resp = '{read_data: '0, ready: 1'b1, error: 1'b1};  // unmapped or unused
      if (addr[4:3] == slave_registers && idx < register_count) begin
         resp.read_data = bank_model[idx];
         resp.error     = 1'b0;
      end else if (addr[4:3] == slave_timer && idx <= timer_reg_status) begin
         resp.error = 1'b0;
         case (idx)
            timer_reg_count:   resp.read_data = count_model;
            timer_reg_control: resp.read_data = control_model;
            timer_reg_compare: resp.read_data = compare_model;
            default:           resp.read_data = a2r_data_t'(status_model);
         endcase
      end
      return resp;
   endfunction

   task automatic update_model(input a2r_addr_t addr, input a2r_data_t data);
      a2r_local_t idx;
      idx = addr[a2r_local_width-1:0];
      if (addr[4:3] == slave_registers && idx < register_count) begin
         bank_model[idx] = data;
      end else if (addr[4:3] == slave_timer) begin
         case (idx)
            timer_reg_count:   count_model = data;       // only read while stopped
            timer_reg_control: begin
               control_model = data;
               if (data[0] && count_model == compare_model)
                  status_model = 1'b1;                  // match on first enabled cycle
            end
            timer_reg_compare: compare_model = data;
            timer_reg_status:  if (data[0]) status_model = 1'b0;
            default: ;                                  // unused indices
         endcase
      end
   endtask

   task automatic issue_command(input logic is_write, input a2r_addr_t addr,
                                input a2r_data_t data);
      expected = expected_response(addr);
      if (is_write)
         update_model(addr, data);
      read       = ~is_write;
      write      = is_write;
      address    = addr;
      write_data = data;
      pending.push_back(expected);
      @(negedge clock);
   endtask

   task automatic finish_burst();
      read  = 1'b0;
      write = 1'b0;
      while (pending.size() != 0)
         @(negedge clock);
   endtask

   initial begin
      a2r_local_t idx;
      a2r_data_t  value;
      void'($urandom(89768));
      reset      = 1'b1;
      read       = 1'b0;
      write      = 1'b0;
      address    = '0;
      write_data = '0;
      expected   = '0;
      foreach (bank_model[i])
         bank_model[i] = '0;
      count_model   = '0;
      control_model = '0;
      compare_model = '0;
      status_model  = 1'b0;
      repeat (10) @(negedge clock);
      reset = 1'b0;

      for (int i = 0; i < 8; i++)                       // everything zero after reset
         issue_command(1'b0, bank_address(3'(i)), '0);
      for (int i = 0; i < 4; i++)
         issue_command(1'b0, timer_address(3'(i)), '0);
      finish_burst();

      for (int i = 0; i < random_writes; i++)
         issue_command(1'b1, bank_address(3'($urandom_range(0, 6))), $urandom());
      for (int i = 0; i < 8; i++) begin                 // read right behind the write
         idx = 3'($urandom_range(0, 6));
         issue_command(1'b1, bank_address(idx), $urandom());
         issue_command(1'b0, bank_address(idx), '0);
      end
      for (int i = 0; i < 7; i++)
         issue_command(1'b0, bank_address(3'(i)), '0);
      finish_burst();

      issue_command(1'b1, bank_address(3'd7), $urandom());
      issue_command(1'b0, bank_address(3'd7), '0);
      for (int i = 4; i < 8; i++) begin
         issue_command(1'b1, timer_address(3'(i)), $urandom());
         issue_command(1'b0, timer_address(3'(i)), '0);
      end
      for (int i = 0; i < 4; i++)                       // used timer registers untouched
         issue_command(1'b0, timer_address(3'(i)), '0);
      for (int i = 0; i < register_count; i++)          // bank unchanged by index 7
         issue_command(1'b0, bank_address(3'(i)), '0);
      for (int i = 0; i < 8; i++)                       // selects 2 and 3
         issue_command(i[0], a2r_addr_t'({2'(2 + i / 4), 3'($urandom_range(0, 7))}), $urandom());
      finish_burst();

      ////////////////////////////////
      // timer load, compare and match
      ////////////////////////////////
      value = $urandom();
      issue_command(1'b1, timer_address(timer_reg_control), '0);
      issue_command(1'b1, timer_address(timer_reg_count), value);
      issue_command(1'b0, timer_address(timer_reg_count), '0);
      issue_command(1'b1, timer_address(timer_reg_compare), value);
      issue_command(1'b1, timer_address(timer_reg_control), 32'd1);
      finish_burst();                                   // match lands a cycle later
      issue_command(1'b0, timer_address(timer_reg_status), '0);
      issue_command(1'b1, timer_address(timer_reg_control), '0);
      issue_command(1'b1, timer_address(timer_reg_status), 32'd1);
      issue_command(1'b0, timer_address(timer_reg_status), '0);
      finish_burst();

      for (int i = 0; i < mixed_commands; i++) begin    // one strobe every cycle
         if ($urandom_range(0, 1) == 0) begin
            issue_command(1'($urandom_range(0, 1)), bank_address(3'($urandom_range(0, 7))),
                          $urandom());
         end else begin
            idx = 3'($urandom_range(1, 3));             // counter stays out, its value drifted
            issue_command(idx != timer_reg_control && $urandom_range(0, 1) == 1,
                          timer_address(idx), $urandom());
         end
      end
      finish_burst();
      repeat (2) @(negedge clock);                      // last checks fire

      if (i_dut.i_asserts.failures == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("Done: errors found");
         $fatal(1, "protocol checks failed");
      end
   end

endmodule

`default_nettype wire

//--- project.f
hdl/a2r_bus_pkg.sv
hdl/a2r_map_pkg.sv
hdl/a2r_request_stage.sv
hdl/a2r_address_decode.sv
hdl/a2r_register_slave.sv
hdl/a2r_timer_slave.sv
hdl/a2r_response_stage.sv
hdl/a2r_register_bus.sv
test/a2r_register_bus_asserts.sv
test/a2r_register_bus_tb.sv

//--- Bender.yml
package:
  name: a2r_register_bus

sources:
  - hdl/a2r_bus_pkg.sv
  - hdl/a2r_map_pkg.sv
  - hdl/a2r_request_stage.sv
  - hdl/a2r_address_decode.sv
  - hdl/a2r_register_slave.sv
  - hdl/a2r_timer_slave.sv
  - hdl/a2r_response_stage.sv
  - hdl/a2r_register_bus.sv
  - target: test
    files:
      - test/a2r_register_bus_asserts.sv
      - test/a2r_register_bus_tb.sv
